//--- src/mem_pkg.sv
package mem_pkg;

  // Line geometry.
  localparam int LINE_BYTES = 16;
  localparam int LINE_WIDTH = LINE_BYTES * 8;

  // Byte-addressed array, addresses wrap at the top.
  localparam int ADDR_WIDTH = 16;
  localparam int MEM_BYTES  = 1 << ADDR_WIDTH;

  // Request input to fill strobe.
  localparam int TOTAL_LATENCY = 10;

endpackage

//--- src/mem_req_arbiter.sv
`timescale 1ns/10ps

module mem_req_arbiter (
  input  logic                           clk_i,
  input  logic                           rst_i,
  input  logic                           ic_rd_req_i,
  input  logic [mem_pkg::ADDR_WIDTH-1:0] ic_addr_i,
  input  logic                           dc_rd_req_i,
  input  logic                           dc_wr_req_i,
  input  logic [mem_pkg::ADDR_WIDTH-1:0] dc_addr_i,
  input  logic [mem_pkg::LINE_WIDTH-1:0] dc_wr_data_i,
  output logic                           req_valid_o,
  output logic                           req_is_wr_o,
  output logic                           req_is_instr_o,
  output logic [mem_pkg::ADDR_WIDTH-1:0] req_addr_o,
  output logic [mem_pkg::LINE_WIDTH-1:0] req_wdata_o
);

  logic                           dc_req;
  logic                           pend_valid_q;
  logic [mem_pkg::ADDR_WIDTH-1:0] pend_addr_q;

  assign dc_req = dc_rd_req_i | dc_wr_req_i;

  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      req_valid_o  <= 1'b0;
      pend_valid_q <= 1'b0;
    end else begin
      req_valid_o <= dc_req | pend_valid_q | ic_rd_req_i;
      if (dc_req) begin
        pend_valid_q <= pend_valid_q | ic_rd_req_i; // Instruction loses, park it.
      end else begin
        pend_valid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    req_wdata_o <= dc_wr_data_i;
    if (dc_req) begin
      req_is_wr_o    <= dc_wr_req_i;
      req_is_instr_o <= 1'b0;
      req_addr_o     <= dc_addr_i;
    end else if (pend_valid_q) begin
      req_is_wr_o    <= 1'b0;
      req_is_instr_o <= 1'b1;
      req_addr_o     <= pend_addr_q; // Oldest instruction request first.
    end else begin
      req_is_wr_o    <= 1'b0;
      req_is_instr_o <= 1'b1;
      req_addr_o     <= ic_addr_i;
    end
    if (dc_req && ic_rd_req_i) begin
      pend_addr_q <= ic_addr_i;
    end
  end

  // The instruction cache waits for its fill, so it never overruns the pending slot.
  a_no_ic_overrun: assert property (
    @(posedge clk_i) disable iff (!rst_i) ic_rd_req_i |-> !pend_valid_q
  );

endmodule

//--- src/mem_delay_line.sv
`timescale 1ns/10ps

module mem_delay_line #(
  parameter int DEPTH = 4,
  parameter int WIDTH = 8
)(
  input  logic             clk_i,
  input  logic             rst_i,
  input  logic             valid_i,
  input  logic [WIDTH-1:0] payload_i,
  output logic             valid_o,
  output logic [WIDTH-1:0] payload_o
);

  logic [DEPTH-1:0] valid_q;
  logic [WIDTH-1:0] payload_q [DEPTH];

  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      valid_q <= '0;
    end else begin
      valid_q[0] <= valid_i;
      for (int i = 1; i < DEPTH; i++) begin
        valid_q[i] <= valid_q[i-1];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    payload_q[0] <= payload_i;
    for (int i = 1; i < DEPTH; i++) begin
      payload_q[i] <= payload_q[i-1];
    end
  end

  assign valid_o   = valid_q[DEPTH-1];
  assign payload_o = payload_q[DEPTH-1];

  a_depth_min: assert property (@(posedge clk_i) DEPTH >= 1);

endmodule

//--- src/mem_line_array.sv
`timescale 1ns/10ps

module mem_line_array (
  input  logic                           clk_i,
  input  logic                           rst_i,
  input  logic                           req_valid_i,
  input  logic                           req_is_wr_i,
  input  logic                           req_is_instr_i,
  input  logic [mem_pkg::ADDR_WIDTH-1:0] req_addr_i,
  input  logic [mem_pkg::LINE_WIDTH-1:0] req_wdata_i,
  output logic                           rd_valid_o,
  output logic                           rd_is_instr_o,
  output logic [mem_pkg::LINE_WIDTH-1:0] rd_data_o
);

  logic [7:0]                     mem_q     [mem_pkg::MEM_BYTES];
  logic [mem_pkg::ADDR_WIDTH-1:0] byte_addr [mem_pkg::LINE_BYTES];

  initial begin
    for (int i = 0; i < mem_pkg::MEM_BYTES; i++) begin
      mem_q[i] = 8'h00;
    end
  end

  // Address wraps at the top of the array.
  always_comb begin
    for (int i = 0; i < mem_pkg::LINE_BYTES; i++) begin
      byte_addr[i] = req_addr_i + mem_pkg::ADDR_WIDTH'(i);
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_valid_i && req_is_wr_i) begin
      for (int i = 0; i < mem_pkg::LINE_BYTES; i++) begin
        mem_q[byte_addr[i]] <= req_wdata_i[8*i +: 8]; // LSB at lowest address.
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_valid_i && !req_is_wr_i) begin
      for (int i = 0; i < mem_pkg::LINE_BYTES; i++) begin
        rd_data_o[8*i +: 8] <= mem_q[byte_addr[i]];
      end
    end
    rd_is_instr_o <= req_is_instr_i;
  end

  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      rd_valid_o <= 1'b0;
    end else begin
      rd_valid_o <= req_valid_i & ~req_is_wr_i; // Writes are silent.
    end
  end

endmodule

//--- src/mem_resp_router.sv
`timescale 1ns/10ps

module mem_resp_router (
  input  logic                           clk_i,
  input  logic                           rst_i,
  input  logic                           rd_valid_i,
  input  logic                           rd_is_instr_i,
  input  logic [mem_pkg::LINE_WIDTH-1:0] rd_data_i,
  output logic                           ic_fill_valid_o,
  output logic                           dc_fill_valid_o,
  output logic [mem_pkg::LINE_WIDTH-1:0] fill_data_o
);

  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      ic_fill_valid_o <= 1'b0;
      dc_fill_valid_o <= 1'b0;
    end else begin
      ic_fill_valid_o <= rd_valid_i & rd_is_instr_i;
      dc_fill_valid_o <= rd_valid_i & ~rd_is_instr_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rd_valid_i) begin
      fill_data_o <= rd_data_i; // Holds last line between fills.
    end
  end

  a_one_fill: assert property (
    @(posedge clk_i) disable iff (!rst_i) !(ic_fill_valid_o && dc_fill_valid_o)
  );

endmodule

//--- src/mem_subsys_top.sv
`timescale 1ns/10ps

module mem_subsys_top #(
  parameter int REQ_STAGES  = 4,
  parameter int RESP_STAGES = 3
)(
  input  logic                           clk_i,
  input  logic                           rst_i,
  input  logic                           ic_rd_req_i,
  input  logic [mem_pkg::ADDR_WIDTH-1:0] ic_addr_i,
  input  logic                           dc_rd_req_i,
  input  logic                           dc_wr_req_i,
  input  logic [mem_pkg::ADDR_WIDTH-1:0] dc_addr_i,
  input  logic [mem_pkg::LINE_WIDTH-1:0] dc_wr_data_i,
  output logic                           ic_fill_valid_o,
  output logic                           dc_fill_valid_o,
  output logic [mem_pkg::LINE_WIDTH-1:0] fill_data_o
);

  localparam int REQ_W  = 2 + mem_pkg::ADDR_WIDTH + mem_pkg::LINE_WIDTH;
  localparam int RESP_W = 1 + mem_pkg::LINE_WIDTH;

  logic                           req_valid;
  logic                           req_is_wr;
  logic                           req_is_instr;
  logic [mem_pkg::ADDR_WIDTH-1:0] req_addr;
  logic [mem_pkg::LINE_WIDTH-1:0] req_wdata;
  logic [REQ_W-1:0]               req_payload;

  logic                           arr_valid;
  logic                           arr_is_wr;
  logic                           arr_is_instr;
  logic [mem_pkg::ADDR_WIDTH-1:0] arr_addr;
  logic [mem_pkg::LINE_WIDTH-1:0] arr_wdata;
  logic [REQ_W-1:0]               arr_payload;

  logic                           rd_valid;
  logic                           rd_is_instr;
  logic [mem_pkg::LINE_WIDTH-1:0] rd_data;

  logic                           rt_valid;
  logic [RESP_W-1:0]              rt_payload;

  assign req_payload = {req_is_wr, req_is_instr, req_addr, req_wdata};
  assign {arr_is_wr, arr_is_instr, arr_addr, arr_wdata} = arr_payload;

  mem_req_arbiter u_arbiter (
    .clk_i, .rst_i, .ic_rd_req_i, .ic_addr_i, .dc_rd_req_i, .dc_wr_req_i,
    .dc_addr_i, .dc_wr_data_i,
    .req_valid_o(req_valid), .req_is_wr_o(req_is_wr), .req_is_instr_o(req_is_instr),
    .req_addr_o(req_addr), .req_wdata_o(req_wdata)
  );

  mem_delay_line #(.DEPTH(REQ_STAGES), .WIDTH(REQ_W)) u_req_delay (
    .clk_i, .rst_i, .valid_i(req_valid), .payload_i(req_payload),
    .valid_o(arr_valid), .payload_o(arr_payload)
  );

  mem_line_array u_array (
    .clk_i, .rst_i, .req_valid_i(arr_valid), .req_is_wr_i(arr_is_wr),
    .req_is_instr_i(arr_is_instr), .req_addr_i(arr_addr), .req_wdata_i(arr_wdata),
    .rd_valid_o(rd_valid), .rd_is_instr_o(rd_is_instr), .rd_data_o(rd_data)
  );

  mem_delay_line #(.DEPTH(RESP_STAGES), .WIDTH(RESP_W)) u_resp_delay (
    .clk_i, .rst_i, .valid_i(rd_valid), .payload_i({rd_is_instr, rd_data}),
    .valid_o(rt_valid), .payload_o(rt_payload)
  );

  mem_resp_router u_router (
    .clk_i, .rst_i, .rd_valid_i(rt_valid), .rd_is_instr_i(rt_payload[RESP_W-1]),
    .rd_data_i(rt_payload[mem_pkg::LINE_WIDTH-1:0]),
    .ic_fill_valid_o, .dc_fill_valid_o, .fill_data_o
  );

  // Arbiter, array and router each add one register.
  a_latency: assert property (
    @(posedge clk_i) REQ_STAGES + RESP_STAGES + 3 == mem_pkg::TOTAL_LATENCY
  );

endmodule

//--- dv/tb_clk_gen.sv
`timescale 1ns/10ps

module tb_clk_gen (
  output logic clk_o,
  output logic rst_o
);

  initial begin
    clk_o = 1'b0;
    forever #2 clk_o = ~clk_o; // 4 ns period.
  end

  initial begin
    rst_o = 1'b0;
    repeat (4) @(posedge clk_o);
    rst_o <= 1'b1;
  end

endmodule

//--- dv/tb_mem_subsys.sv
`timescale 1ns/10ps

module tb_mem_subsys;

  localparam int ZERO_READS      = 4;
  localparam int EDGE_ADDRS      = 4;
  localparam int WR_RD_PAIRS     = 8;
  localparam int COLLISIONS      = 4;
  localparam int STREAM_LEN      = 200;
  localparam int N_REQUESTS      = ZERO_READS + 3 * EDGE_ADDRS + 2 * WR_RD_PAIRS
                                   + 4 * COLLISIONS + STREAM_LEN;
  localparam int WATCHDOG_CYCLES = N_REQUESTS * 12 + 200;
  localparam int LAT             = mem_pkg::TOTAL_LATENCY;

  logic                           clk;
  logic                           rst;
  logic                           ic_rd_req;
  logic [mem_pkg::ADDR_WIDTH-1:0] ic_addr;
  logic                           dc_rd_req;
  logic                           dc_wr_req;
  logic [mem_pkg::ADDR_WIDTH-1:0] dc_addr;
  logic [mem_pkg::LINE_WIDTH-1:0] dc_wr_data;
  logic                           ic_fill_valid;
  logic                           dc_fill_valid;
  logic [mem_pkg::LINE_WIDTH-1:0] fill_data;

  logic [7:0]                     shadow [mem_pkg::MEM_BYTES];
  logic                           exp_instr_q [$];
  logic [mem_pkg::LINE_WIDTH-1:0] exp_line_q [$];
  int                             exp_due_q [$];
  logic                           exp_ic = 1'b0;
  logic                           exp_dc = 1'b0;
  logic [mem_pkg::LINE_WIDTH-1:0] exp_line = '0;
  logic [mem_pkg::ADDR_WIDTH-1:0] edge_addrs [EDGE_ADDRS] = '{16'hfff8, 16'hffff, 16'h1233,
                                                               16'h0007};
  logic [31:0]                    lfsr_q = 32'h2e6a_776c;
  int                             cyc = 0;
  int                             strobe_errs = 0;
  int                             data_errs = 0;
  int                             proto_errs = 0;
  string                          test_name = "reset";

  tb_clk_gen u_clk_gen (.clk_o(clk), .rst_o(rst));

  mem_subsys_top #(.REQ_STAGES(4), .RESP_STAGES(3)) u_mem_subsys_top (
    .clk_i(clk), .rst_i(rst), .ic_rd_req_i(ic_rd_req), .ic_addr_i(ic_addr),
    .dc_rd_req_i(dc_rd_req), .dc_wr_req_i(dc_wr_req), .dc_addr_i(dc_addr),
    .dc_wr_data_i(dc_wr_data), .ic_fill_valid_o(ic_fill_valid),
    .dc_fill_valid_o(dc_fill_valid), .fill_data_o(fill_data)
  );

  // Taps 32, 22, 2, 1.
  function automatic logic lfsr_bit();
    logic fb;
    fb = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
    lfsr_q = {lfsr_q[30:0], fb};
    return fb;
  endfunction

  function automatic logic [mem_pkg::LINE_WIDTH-1:0] random_bits(input int n);
    logic [mem_pkg::LINE_WIDTH-1:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v[i] = lfsr_bit();
    end
    return v;
  endfunction

  // Lowest address holds the least significant byte, addresses wrap.
  function automatic logic [mem_pkg::LINE_WIDTH-1:0] shadow_line(input logic [15:0] addr);
    logic [mem_pkg::LINE_WIDTH-1:0] line;
    logic [15:0]                    a;
    for (int i = 0; i < mem_pkg::LINE_BYTES; i++) begin
      a = addr + 16'(i);
      line[8*i +: 8] = shadow[a];
    end
    return line;
  endfunction

  task automatic shadow_store(input logic [15:0] addr, input logic [127:0] line);
    logic [15:0] a;
    for (int i = 0; i < mem_pkg::LINE_BYTES; i++) begin
      a = addr + 16'(i);
      shadow[a] = line[8*i +: 8];
    end
  endtask

  // Request is high in the cycle after the current one.
  task automatic expect_fill(input logic instr, input logic [15:0] addr, input int delay);
    exp_instr_q.push_back(instr);
    exp_line_q.push_back(shadow_line(addr));
    exp_due_q.push_back(cyc + 1 + delay);
  endtask

  task automatic drive_request(input logic ic_rd, input logic dc_rd, input logic dc_wr,
                               input logic [15:0] ia, input logic [15:0] da,
                               input logic [127:0] wd);
    @(posedge clk);
    ic_rd_req  <= ic_rd;
    dc_rd_req  <= dc_rd;
    dc_wr_req  <= dc_wr;
    ic_addr    <= ia;
    dc_addr    <= da;
    dc_wr_data <= wd;
  endtask

  task automatic idle_cycle();
    drive_request(1'b0, 1'b0, 1'b0, ic_addr, dc_addr, '0);
  endtask

  task automatic read_dc(input logic [15:0] addr);
    drive_request(1'b0, 1'b1, 1'b0, ic_addr, addr, '0);
    expect_fill(1'b0, addr, LAT);
  endtask

  task automatic read_ic(input logic [15:0] addr);
    drive_request(1'b1, 1'b0, 1'b0, addr, dc_addr, '0);
    expect_fill(1'b1, addr, LAT);
  endtask

  task automatic write_dc(input logic [15:0] addr, input logic [127:0] line);
    drive_request(1'b0, 1'b0, 1'b1, ic_addr, addr, line);
    shadow_store(addr, line);
  endtask

  // Data wins, the parked instruction read goes out one cycle later.
  task automatic read_both(input logic [15:0] ia, input logic [15:0] da);
    drive_request(1'b1, 1'b1, 1'b0, ia, da, '0);
    expect_fill(1'b0, da, LAT);
    expect_fill(1'b1, ia, LAT + 1);
  endtask

  task automatic drain_fills();
    while (exp_due_q.size() != 0) begin
      idle_cycle();
    end
    repeat (2) idle_cycle();
  endtask

  always @(posedge clk) begin
    cyc <= cyc + 1;
  end

  // Presents the fill due in the coming cycle.
  always @(posedge clk) begin
    logic instr;
    if (exp_due_q.size() != 0 && exp_due_q[0] == cyc + 1) begin
      instr = exp_instr_q.pop_front();
      exp_ic   <= instr;
      exp_dc   <= !instr;
      exp_line <= exp_line_q.pop_front();
      void'(exp_due_q.pop_front());
    end else begin
      exp_ic <= 1'b0;
      exp_dc <= 1'b0;
    end
  end

  a_reset_quiet: assert property (@(posedge clk) !rst |=> !ic_fill_valid && !dc_fill_valid)
    else begin
      strobe_errs++;
      $display("CHECK FAILED reset: fill strobes expected 00 actual %b%b",
               $sampled(ic_fill_valid), $sampled(dc_fill_valid));
    end

  a_ic_strobe: assert property (@(posedge clk) disable iff (!rst) ic_fill_valid == exp_ic)
    else begin
      strobe_errs++;
      $display("CHECK FAILED %s: ic_fill_valid expected %b actual %b at cycle %0d",
               test_name, $sampled(exp_ic), $sampled(ic_fill_valid), cyc);
    end

  a_dc_strobe: assert property (@(posedge clk) disable iff (!rst) dc_fill_valid == exp_dc)
    else begin
      strobe_errs++;
      $display("CHECK FAILED %s: dc_fill_valid expected %b actual %b at cycle %0d",
               test_name, $sampled(exp_dc), $sampled(dc_fill_valid), cyc);
    end

  a_fill_data: assert property (
    @(posedge clk) disable iff (!rst) (exp_ic || exp_dc) |-> fill_data == exp_line
  ) else begin
      data_errs++;
      $display("CHECK FAILED %s: fill_data expected %h actual %h",
               test_name, $sampled(exp_line), $sampled(fill_data));
    end

  a_single_fill: assert property (
    @(posedge clk) disable iff (!rst) !(ic_fill_valid && dc_fill_valid)
  ) else begin
      proto_errs++;
      $display("Both fill strobes were high in the same cycle during %s.", test_name);
    end

  initial begin
    logic [15:0] addr;
    logic [15:0] addr_b;
    ic_rd_req  = 1'b0;
    ic_addr    = '0;
    dc_rd_req  = 1'b0;
    dc_wr_req  = 1'b0;
    dc_addr    = '0;
    dc_wr_data = '0;
    for (int i = 0; i < mem_pkg::MEM_BYTES; i++) begin
      shadow[i] = 8'h00;
    end
    @(posedge rst);

    test_name = "reset_zero";
    for (int i = 0; i < ZERO_READS; i++) begin
      addr = 16'(random_bits(16));
      if (i % 2 == 0) begin
        read_dc(addr);
      end else begin
        read_ic(addr);
        drain_fills(); // One instruction read outstanding.
      end
    end
    drain_fills();

    test_name = "edge_reads";
    for (int i = 0; i < EDGE_ADDRS; i++) begin
      write_dc(edge_addrs[i], random_bits(128));
    end
    for (int i = 0; i < EDGE_ADDRS; i++) begin
      read_dc(edge_addrs[i]);
    end
    for (int i = 0; i < EDGE_ADDRS; i++) begin
      read_ic(edge_addrs[i]);
      drain_fills();
    end

    test_name = "write_then_read";
    for (int i = 0; i < WR_RD_PAIRS; i++) begin
      addr = 16'(random_bits(16));
      write_dc(addr, random_bits(128));
      if (i % 2 == 0) begin
        read_dc(addr);
      end else begin
        read_ic(addr);
      end
      drain_fills();
    end

    test_name = "collision";
    for (int i = 0; i < COLLISIONS; i++) begin
      addr   = 16'(random_bits(16));
      addr_b = 16'(random_bits(16));
      write_dc(addr, random_bits(128));
      write_dc(addr_b, random_bits(128));
      read_both(addr, addr_b);
      drain_fills();
    end

    test_name = "random_stream";
    for (int i = 0; i < STREAM_LEN; i++) begin
      addr = 16'hff80 + 16'(random_bits(8)); // Narrow window near the top.
      if (lfsr_bit()) begin
        write_dc(addr, random_bits(128));
      end else begin
        read_dc(addr);
      end
    end
    drain_fills();

    $display("Error counts: strobe %0d, data %0d, protocol %0d",
             strobe_errs, data_errs, proto_errs);
    if (strobe_errs + data_errs + proto_errs == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Watchdog expired after %0d cycles, the run did not complete.", WATCHDOG_CYCLES);
    $display("Error counts: strobe %0d, data %0d, protocol %0d",
             strobe_errs, data_errs, proto_errs);
    $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

//--- project.f
src/mem_pkg.sv
src/mem_req_arbiter.sv
src/mem_delay_line.sv
src/mem_line_array.sv
src/mem_resp_router.sv
src/mem_subsys_top.sv
dv/tb_clk_gen.sv
dv/tb_mem_subsys.sv

//--- Makefile
TOP := tb_mem_subsys

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): project.f $(wildcard src/*.sv dv/*.sv)
	verilator --binary --timing --assert -f project.f --top-module $(TOP)

run: obj_dir/V$(TOP)
	obj_dir/V$(TOP) | tee /dev/stderr | grep -q "ALL TESTS PASSED"

lint:
	verilator --lint-only --timing --assert -f project.f --top-module $(TOP)

clean:
	rm -rf obj_dir
